// ==== rtl/fm_pkg.sv ====
package fm_pkg;

   //////////////////////////////
   // Sizes and constants
   //////////////////////////////

   // Buffer geometry
   localparam int ADDR_W     = 11;
   localparam int DATA_W     = 16;
   // Nibble pointer, four nibbles per word
   localparam int NIB_ADDR_W = ADDR_W + 2;

   // Oscillator
   localparam int PHASE_W = 24;
   // clk/16 with a zero sample
   localparam logic [PHASE_W-1:0] BASE_INC = 24'h100000;

   // Fixed UART bit period in clocks
   localparam int BIT_CLKS = 16;

   // Restart pulse length in cycles
   localparam int RESTART_LEN = 3;

   //////////////////////////////
   // Encodings
   //////////////////////////////

   // Command opcodes in the low nibble of a byte
   typedef enum logic [3:0] {
      op_wr_reset  = 4'd0,
      op_wr_nibble = 4'd1,
      op_div_lo    = 4'd2,
      op_div_hi    = 4'd3,
      op_restart   = 4'd4,
      op_dump      = 4'd15
   } opcode_e;

   // Buffer dump FSM
   typedef enum logic [1:0] {
      st_idle,
      st_sending,
      st_final
   } dump_state_e;

   //////////////////////////////
   // Strobes between blocks
   //////////////////////////////

   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } ram_wr_t;

   typedef struct packed {
      logic restart;
      logic dump;
   } ctrl_t;

endpackage

// ==== rtl/uart_rx.sv ====
module uart_rx (
   input  logic       clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   output logic       o_rx_valid,
   output logic [7:0] o_rx_data
);
   import fm_pkg::*;

   typedef logic [$clog2(BIT_CLKS)-1:0] bit_cnt_t;

   logic [2:0] sync_q;
   logic       rx_s;
   logic       start_edge;
   logic       busy;
   bit_cnt_t   clk_cnt;
   logic [3:0] bit_idx;
   logic [7:0] shreg;
   logic       bit_mid;

   // Line idles high
   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sync_q <= 3'b111;
      end else begin
         sync_q <= {sync_q[1:0], i_rx};
      end
   end

   assign rx_s       = sync_q[1];
   assign start_edge = sync_q[2] & ~sync_q[1];
   assign bit_mid    = busy && (clk_cnt == '0);

   //////////////////////////////
   // Frame timing
   //////////////////////////////

   // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy       <= 1'b0;
         clk_cnt    <= '0;
         bit_idx    <= '0;
         o_rx_valid <= 1'b0;
      end else begin
         o_rx_valid <= 1'b0;
         if (!busy) begin
            if (start_edge) begin
               busy    <= 1'b1;
               clk_cnt <= bit_cnt_t'(BIT_CLKS / 2 - 1);
               bit_idx <= '0;
            end
         end else if (clk_cnt != '0) begin
            clk_cnt <= clk_cnt - 1'b1;
         end else begin
            clk_cnt <= bit_cnt_t'(BIT_CLKS - 1);
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx == 4'd0) begin
               // Glitch, not a real start bit
               if (rx_s)
                  busy <= 1'b0;
            end else if (bit_idx == 4'd9) begin
               busy       <= 1'b0;
               o_rx_valid <= rx_s;
            end
         end
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk) begin
      if (bit_mid) begin
         if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
            shreg <= {rx_s, shreg[7:1]};
         if (bit_idx == 4'd9)
            o_rx_data <= shreg;
      end
   end

   a_valid_single: assert property (@(posedge clk) disable iff (!i_nrst)
      o_rx_valid |=> !o_rx_valid);

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx (
   input  logic       clk,
   input  logic       i_nrst,
   input  logic       i_start,
   input  logic [7:0] i_data,
   output logic       o_busy,
   output logic       o_tx
);
   import fm_pkg::*;

   typedef logic [$clog2(BIT_CLKS)-1:0] bit_cnt_t;

   logic       busy;
   bit_cnt_t   clk_cnt;
   logic [3:0] bit_idx;
   // Data bits followed by the stop bit
   logic [8:0] shreg;
   logic       tx_q;

   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy    <= 1'b0;
         clk_cnt <= '0;
         bit_idx <= '0;
         shreg   <= '1;
         tx_q    <= 1'b1;
      end else if (!busy) begin
         if (i_start) begin
            busy    <= 1'b1;
            tx_q    <= 1'b0;
            shreg   <= {1'b1, i_data};
            clk_cnt <= bit_cnt_t'(BIT_CLKS - 1);
            bit_idx <= '0;
         end
      end else if (clk_cnt != '0) begin
         clk_cnt <= clk_cnt - 1'b1;
      end else if (bit_idx == 4'd9) begin
         // End of stop bit, line already high
         busy <= 1'b0;
      end else begin
         tx_q    <= shreg[0];
         shreg   <= {1'b1, shreg[8:1]};
         bit_idx <= bit_idx + 4'd1;
         clk_cnt <= bit_cnt_t'(BIT_CLKS - 1);
      end
   end

   assign o_busy = busy;
   assign o_tx   = tx_q;

   // The player must hold off until the frame ends
   a_no_start_busy: assert property (@(posedge clk) disable iff (!i_nrst)
      i_start |-> !o_busy);

endmodule

// ==== rtl/cmd_decoder.sv ====
module cmd_decoder (
   input  logic            clk,
   input  logic            i_nrst,
   input  logic            i_rx_valid,
   input  logic [7:0]      i_rx_data,
   output fm_pkg::ram_wr_t o_ram_wr,
   output fm_pkg::ctrl_t   o_ctrl,
   output logic [7:0]      o_sample_top
);
   import fm_pkg::*;

   opcode_e                op;
   logic [3:0]             nib;
   logic                   nib_wr;
   logic [NIB_ADDR_W-1:0]  nibble_ptr;
   logic                   we_q;
   logic [ADDR_W-1:0]      addr_q;
   logic [DATA_W-1:0]      data_q;
   logic [RESTART_LEN-1:0] restart_sr;
   logic                   dump_q;

   assign op     = opcode_e'(i_rx_data[3:0]);
   assign nib    = i_rx_data[7:4];
   assign nib_wr = i_rx_valid && (op == op_wr_nibble);

   //////////////////////////////
   // Control registers
   //////////////////////////////

   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst) begin
         nibble_ptr   <= '0;
         we_q         <= 1'b0;
         o_sample_top <= '0;
         restart_sr   <= '0;
         dump_q       <= 1'b0;
      end else begin
         we_q       <= nib_wr;
         restart_sr <= {restart_sr[RESTART_LEN-2:0], i_rx_valid && (op == op_restart)};
         dump_q     <= i_rx_valid && (op == op_dump);
         // Advance once the write has gone out
         if (we_q)
            nibble_ptr <= nibble_ptr + 1'b1;
         if (i_rx_valid) begin
            case (op)
               op_wr_reset: nibble_ptr <= '0;
               op_div_lo:   o_sample_top[3:0] <= nib;
               op_div_hi:   o_sample_top[7:4] <= nib;
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////
   // Word assembly
   //////////////////////////////

   // New nibble enters at the top, word done after four
   always_ff @(posedge clk) begin
      if (nib_wr) begin
         data_q <= {nib, data_q[DATA_W-1:4]};
         addr_q <= nibble_ptr[NIB_ADDR_W-1:2];
      end
   end

   assign o_ram_wr = '{we: we_q, addr: addr_q, data: data_q};
   assign o_ctrl   = '{restart: |restart_sr, dump: dump_q};

endmodule

// ==== rtl/sample_ram.sv ====
module sample_ram (
   input  logic                      clk,
   input  fm_pkg::ram_wr_t           i_wr,
   input  logic [fm_pkg::ADDR_W-1:0] i_raddr,
   output logic [fm_pkg::DATA_W-1:0] o_rdata
);
   import fm_pkg::*;

   logic [DATA_W-1:0] mem [2**ADDR_W];

   // Write port
   always_ff @(posedge clk) begin
      if (i_wr.we)
         mem[i_wr.addr] <= i_wr.data;
   end

   // Read port, one cycle latency
   always_ff @(posedge clk) begin
      o_rdata <= mem[i_raddr];
   end

endmodule

// ==== rtl/sample_player.sv ====
module sample_player (
   input  logic                      clk,
   input  logic                      i_nrst,
   input  logic [7:0]                i_sample_top,
   input  fm_pkg::ctrl_t             i_ctrl,
   input  logic [fm_pkg::DATA_W-1:0] i_rdata,
   input  logic                      i_tx_busy,
   output logic [fm_pkg::ADDR_W-1:0] o_raddr,
   output logic                      o_tx_start,
   output logic [7:0]                o_tx_data
);
   import fm_pkg::*;

   logic [7:0]        sample_cnt;
   logic              tick;
   logic [ADDR_W-1:0] rd_ptr;
   // Address of the word now on i_rdata
   logic [ADDR_W-1:0] data_addr;
   logic [ADDR_W:0]   send_ptr;
   dump_state_e       state;
   logic              word_zero;
   logic              ptr_match;
   logic              tx_fire;

   //////////////////////////////
   // Sample rate tick
   //////////////////////////////

   assign tick = (sample_cnt == i_sample_top);

   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst)
         sample_cnt <= '0;
      else if (tick)
         sample_cnt <= '0;
      else
         sample_cnt <= sample_cnt + 8'd1;
   end

   //////////////////////////////
   // Playback pointer
   //////////////////////////////

   assign word_zero = (i_rdata == '0);

   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rd_ptr    <= '0;
         data_addr <= '0;
      end else begin
         data_addr <= rd_ptr;
         if (i_ctrl.restart)
            rd_ptr <= '0;
         else if (tick)
            rd_ptr <= word_zero ? '0 : rd_ptr + 1'b1;
      end
   end

   //////////////////////////////
   // Buffer dump
   //////////////////////////////

   // Wait until playback reaches the word being sent
   assign ptr_match = (send_ptr[ADDR_W:1] == data_addr);
   assign tx_fire   = (state != st_idle) && ptr_match && !i_tx_busy && tick;

   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= st_idle;
         send_ptr <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (i_ctrl.dump) begin
                  state    <= st_sending;
                  send_ptr <= '0;
               end
            end
            st_sending: begin
               if (tx_fire) begin
                  send_ptr <= send_ptr + 1'b1;
                  if (word_zero)
                     state <= st_final;
               end
            end
            st_final: begin
               if (tx_fire)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   assign o_raddr    = rd_ptr;
   assign o_tx_start = tx_fire;
   // Low byte on even send_ptr
   assign o_tx_data  = send_ptr[0] ? i_rdata[15:8] : i_rdata[7:0];

   a_start_not_idle: assert property (@(posedge clk) disable iff (!i_nrst)
      o_tx_start |-> (state != st_idle));

endmodule

// ==== rtl/fm_nco.sv ====
module fm_nco (
   input  logic                      clk,
   input  logic                      i_nrst,
   input  logic                      i_clear,
   input  logic [fm_pkg::DATA_W-1:0] i_sample,
   output logic                      o_fm
);
   import fm_pkg::*;

   logic [PHASE_W-1:0] inc_q;
   logic [PHASE_W-1:0] phase;

   //////////////////////////////
   // Increment
   //////////////////////////////

   // Sample shifts the carrier upward only
   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst)
         inc_q <= BASE_INC;
      else
         inc_q <= BASE_INC + PHASE_W'(i_sample);
   end

   //////////////////////////////
   // Phase accumulator
   //////////////////////////////

   always_ff @(posedge clk or negedge i_nrst) begin
      if (!i_nrst)
         phase <= '0;
      else if (i_clear)
         phase <= '0;
      else
         phase <= phase + inc_q;
   end

   // Square wave at the accumulator rate
   assign o_fm = phase[PHASE_W-1];

endmodule

// ==== rtl/fm_tx_top.sv ====
module fm_tx_top (
   input  logic clk,
   input  logic i_nrst,
   input  logic i_rx,
   output logic o_tx,
   output logic o_fm
);
   import fm_pkg::*;

   logic              rx_valid;
   logic [7:0]        rx_data;
   ram_wr_t           ram_wr;
   ctrl_t             ctrl;
   logic [7:0]        sample_top;
   logic [ADDR_W-1:0] raddr;
   logic [DATA_W-1:0] rdata;
   logic              tx_start;
   logic [7:0]        tx_data;
   logic              tx_busy;

   //////////////////////////////
   // Command path
   //////////////////////////////

   uart_rx u_uart_rx (
      .clk        (clk),
      .i_nrst     (i_nrst),
      .i_rx       (i_rx),
      .o_rx_valid (rx_valid),
      .o_rx_data  (rx_data)
   );

   cmd_decoder u_cmd_decoder (
      .clk          (clk),
      .i_nrst       (i_nrst),
      .i_rx_valid   (rx_valid),
      .i_rx_data    (rx_data),
      .o_ram_wr     (ram_wr),
      .o_ctrl       (ctrl),
      .o_sample_top (sample_top)
   );

   //////////////////////////////
   // Buffer and playback
   //////////////////////////////

   sample_ram u_sample_ram (
      .clk     (clk),
      .i_wr    (ram_wr),
      .i_raddr (raddr),
      .o_rdata (rdata)
   );

   sample_player u_sample_player (
      .clk          (clk),
      .i_nrst       (i_nrst),
      .i_sample_top (sample_top),
      .i_ctrl       (ctrl),
      .i_rdata      (rdata),
      .i_tx_busy    (tx_busy),
      .o_raddr      (raddr),
      .o_tx_start   (tx_start),
      .o_tx_data    (tx_data)
   );

   // Restart also realigns the carrier phase
   fm_nco u_fm_nco (
      .clk      (clk),
      .i_nrst   (i_nrst),
      .i_clear  (ctrl.restart),
      .i_sample (rdata),
      .o_fm     (o_fm)
   );

   uart_tx u_uart_tx (
      .clk     (clk),
      .i_nrst  (i_nrst),
      .i_start (tx_start),
      .i_data  (tx_data),
      .o_busy  (tx_busy),
      .o_tx    (o_tx)
   );

endmodule

// ==== dv/tb_fm_tx.sv ====
module tb_fm_tx;
   timeunit 1ns;
   timeprecision 1ps;

   import fm_pkg::*;

   // Words written per test
   localparam int N_FILL    = 8;
   localparam int N_OVER    = 4;
   localparam int N_PACED   = 5;
   localparam int N_CARRIER = 30;
   localparam int N_DUMPS   = 4;
   localparam int FM_WINDOW = 4096;
   localparam int FRAME_CLKS = 10 * BIT_CLKS;
   // Command and reply frames of all tests, rounded up
   localparam int FRAMES = 6 * (N_FILL + N_OVER + N_PACED + N_CARRIER + 8) + 60;
   // A paced dump may wait a whole playback loop per byte
   localparam int PACED_CLKS = 2 * (2 * N_PACED + 2) * (N_PACED + 4) * 256;
   localparam int RX_WAIT = (N_PACED + 4) * 256 + 2 * FRAME_CLKS;
   localparam int LIMIT_NS = 4 * (FRAMES * FRAME_CLKS + PACED_CLKS + FM_WINDOW +
                                  N_DUMPS * RX_WAIT) + 100000;

   logic        clk;
   logic        i_nrst;
   logic        i_rx;
   logic        o_tx;
   logic        o_fm;
   int          seed = 32'h3915;
   int          errors;
   int          checks;
   int          cycle = 0;
   int          top;
   logic [15:0] model_mem [2**ADDR_W];
   logic [15:0] model_shift;
   logic [12:0] model_ptr;
   logic [7:0]  rx_q [$];
   int          start_q [$];

   fm_tx_top uut (
      .clk    (clk),
      .i_nrst (i_nrst),
      .i_rx   (i_rx),
      .o_tx   (o_tx),
      .o_fm   (o_fm)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   //////////////////////////////
   // UART driver and monitor
   //////////////////////////////

   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      int i;
      frame = {1'b1, b, 1'b0};
      for (i = 0; i < 10; i++) begin
         i_rx = frame[0];
         frame = frame >> 1;
         repeat (BIT_CLKS) @(negedge clk);
      end
   endtask

   task automatic send_cmd(input logic [3:0] arg, input logic [3:0] op);
      send_byte({arg, op});
   endtask

   // Mid bit sampling on the falling edge
   task automatic recv_byte(input string name, output bit ok);
      int waited;
      int i;
      logic [7:0] b;
      ok = 1'b0;
      waited = 0;
      b = '0;
      while (o_tx === 1'b1 && waited < RX_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (o_tx !== 1'b0) begin
         $display("%s: no start bit from the DUT within %0d cycles", name, RX_WAIT);
         errors++;
         return;
      end
      start_q.push_back(cycle);
      repeat (BIT_CLKS / 2) @(negedge clk);
      for (i = 0; i < 8; i++) begin
         repeat (BIT_CLKS) @(negedge clk);
         b = {o_tx, b[7:1]};
      end
      repeat (BIT_CLKS) @(negedge clk);
      if (o_tx !== 1'b1) begin
         $display("%s: stop bit of a received byte is low", name);
         errors++;
      end
      rx_q.push_back(b);
      ok = 1'b1;
   endtask

   //////////////////////////////
   // Buffer model
   //////////////////////////////

   function automatic logic [15:0] rand_word();
      logic [15:0] w;
      w = 16'($random(seed));
      if (w == 16'h0)
         w = 16'h1;
      return w;
   endfunction

   task automatic write_reset();
      send_cmd(4'h0, op_wr_reset);
      model_ptr = '0;
   endtask

   // Lowest nibble first, each nibble written through to the word
   task automatic write_word(input logic [15:0] word);
      logic [15:0] w;
      int i;
      w = word;
      for (i = 0; i < 4; i++) begin
         send_cmd(w[3:0], op_wr_nibble);
         model_shift = {w[3:0], model_shift[15:4]};
         model_mem[model_ptr[12:2]] = model_shift;
         model_ptr = model_ptr + 13'd1;
         w = w >> 4;
      end
   endtask

   // Zero terminator plus a zero guard after it
   task automatic write_terminator();
      write_word(16'h0);
      write_word(16'h0);
   endtask

   task automatic send_restart();
      send_cmd(4'h0, op_restart);
   endtask

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Words up to the zero word, then the extra final byte
   task automatic dump_check(input string name);
      logic [10:0] zero_addr;
      logic [15:0] w;
      logic [7:0]  exp_b;
      int n;
      int i;
      int waited;
      bit ok;
      zero_addr = '0;
      while (model_mem[zero_addr] != 16'h0)
         zero_addr = zero_addr + 11'd1;
      n = 2 * int'(zero_addr) + 2;
      rx_q.delete();
      start_q.delete();
      ok = 1'b1;
      fork
         send_cmd(4'h0, op_dump);
         for (i = 0; i < n && ok; i++)
            recv_byte(name, ok);
      join
      // The dump ends with the line idle after the final byte
      if (ok) begin
         waited = 0;
         while (o_tx === 1'b1 && waited < RX_WAIT) begin
            @(negedge clk);
            waited++;
         end
         checks++;
         if (o_tx !== 1'b1) begin
            $display("%s: DUT sent more than %0d bytes", name, n);
            errors++;
         end
      end
      for (i = 0; i < rx_q.size(); i++) begin
         w = model_mem[11'(i / 2)];
         exp_b = (i % 2 == 0) ? w[7:0] : w[15:8];
         checks++;
         if (rx_q[i] !== exp_b) begin
            $display("MISMATCH %s byte %0d expected %02h actual %02h",
                     name, i, exp_b, rx_q[i]);
            errors++;
         end
      end
   endtask

   // Bytes start on ticks only
   task automatic gap_check(input string name);
      int i;
      int gap;
      for (i = 1; i < start_q.size(); i++) begin
         gap = start_q[i] - start_q[i-1];
         checks++;
         if (gap < top + 1 || gap % (top + 1) != 0) begin
            $display("MISMATCH %s gap %0d expected multiple of %0d actual %0d",
                     name, i, top + 1, gap);
            errors++;
         end
      end
   endtask

   task automatic print_result(input string name, input int err_before);
      if (errors == err_before)
         $display("test %s ok", name);
      else
         $display("test %s FAILED, %0d bad checks", name, errors - err_before);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial begin
      int e0;
      int i;
      longint edges;
      longint num;
      longint expect_edges;
      logic fm_prev;
      logic [15:0] s;
      i_nrst = 1'b0;
      i_rx = 1'b1;
      errors = 0;
      checks = 0;
      top = 0;
      model_ptr = '0;
      model_shift = '0;
      repeat (4) @(negedge clk);

      e0 = errors;
      checks += 2;
      if (o_tx !== 1'b1) begin
         $display("MISMATCH reset_state o_tx expected 1 actual %b", o_tx);
         errors++;
      end
      if (o_fm !== 1'b0) begin
         $display("MISMATCH reset_state o_fm expected 0 actual %b", o_fm);
         errors++;
      end
      i_nrst = 1'b1;
      print_result("reset_state", e0);
      repeat (4) @(negedge clk);

      e0 = errors;
      write_reset();
      for (i = 0; i < N_FILL; i++)
         write_word(rand_word());
      write_terminator();
      send_restart();
      dump_check("fill_dump");
      print_result("fill_dump", e0);

      e0 = errors;
      write_reset();
      for (i = 0; i < N_OVER; i++)
         write_word(rand_word());
      send_restart();
      dump_check("overwrite");
      print_result("overwrite", e0);

      // Divider still zero, one sample per clock
      e0 = errors;
      // Large sample so its shift stands well clear of the tolerance
      s = rand_word() | 16'h8000;
      write_reset();
      for (i = 0; i < N_CARRIER; i++)
         write_word(s);
      write_terminator();
      send_restart();
      repeat (16) @(negedge clk);
      edges = 0;
      fm_prev = o_fm;
      for (i = 0; i < FM_WINDOW; i++) begin
         @(negedge clk);
         if (o_fm && !fm_prev)
            edges++;
         fm_prev = o_fm;
      end
      // One zero word per loop of sample words
      num = longint'(BASE_INC) * longint'(N_CARRIER + 1) + longint'(s) * longint'(N_CARRIER);
      expect_edges = num * longint'(FM_WINDOW) /
                     (longint'(N_CARRIER + 1) * (longint'(1) << PHASE_W));
      checks++;
      if (edges < expect_edges - 2 || edges > expect_edges + 2) begin
         $display("MISMATCH fm_freq edges expected %0d (+/-2) actual %0d", expect_edges, edges);
         errors++;
      end
      print_result("fm_freq", e0);

      e0 = errors;
      write_reset();
      for (i = 0; i < N_PACED; i++)
         write_word(rand_word());
      write_terminator();
      top = 192 + ($random(seed) & 63);
      send_cmd(4'(top), op_div_lo);
      send_cmd(4'(top >> 4), op_div_hi);
      send_restart();
      dump_check("div_pacing");
      gap_check("div_pacing");
      print_result("div_pacing", e0);

      // Pointer at word 0, so a stray nibble write shows in the dump
      e0 = errors;
      write_reset();
      for (i = 5; i < 15; i++)
         send_cmd(4'($random(seed)), 4'(i));
      dump_check("ignored_ops");
      gap_check("ignored_ops");
      print_result("ignored_ops", e0);

      $display("checks %0d, failures %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   initial begin
      #(LIMIT_NS);
      $display("Watchdog expired after %0d ns, DUT stopped responding", LIMIT_NS);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== project.f ====
rtl/fm_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_decoder.sv
rtl/sample_ram.sv
rtl/sample_player.sv
rtl/fm_nco.sv
rtl/fm_tx_top.sv
dv/tb_fm_tx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FM transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_fm_tx -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_fm_tx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "No errors"; then
   exit 0
fi
exit 1
